/* source/scope_pkg.sv */
////////////////////////////////////////
// Scope channel package
// Sample and buffer widths, sample type,
// acquisition states and trigger sources
////////////////////////////////////////

package scope_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // ADC sample width
  localparam int unsigned ADC_W = 16;

  // Capture buffer address width and depth
  localparam int unsigned BUF_AW    = 10;
  localparam int unsigned BUF_DEPTH = 2 ** BUF_AW;

  // Decimation field width
  localparam int unsigned DEC_W = 8;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Two's complement sample
  typedef logic signed [ADC_W-1:0] sample_t;

  // Buffer address, also used for phase lengths
  typedef logic [BUF_AW-1:0] addr_t;

  // Acquisition phases
  typedef enum logic [2:0] {
    ACQ_IDLE  = 3'd0,
    ACQ_PRE   = 3'd1,
    ACQ_ARMED = 3'd2,
    ACQ_POST  = 3'd3,
    ACQ_DONE  = 3'd4
  } acq_state_t;

  // Trigger sources
  typedef enum logic [1:0] {
    TRG_SW  = 2'd0,
    TRG_EXT = 2'd1,
    TRG_POS = 2'd2,
    TRG_NEG = 2'd3
  } trg_src_t;

endpackage

/* source/adc_input_fmt.sv */
////////////////////////////////////////
// ADC input format
// IO register for raw ADC data with
// offset binary to two's complement
// conversion, negative slope
////////////////////////////////////////

`timescale 1ns/1ns

module adc_input_fmt (
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // Raw ADC bus
  input  logic [scope_pkg::ADC_W-1:0]   adc_dat_i,
  // Converted sample
  output scope_pkg::sample_t            smp_o
);

  import scope_pkg::*;

  // Raw data register, stands in for the IO block register
  logic [ADC_W-1:0] adc_raw;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      adc_raw <= '0;
    end else begin
      adc_raw <= adc_dat_i;
    end
  end

  // Keep the raw MSB, invert the rest
  // Offset binary becomes two's complement with the input slope reversed
  assign smp_o = {adc_raw[ADC_W-1], ~adc_raw[ADC_W-2:0]};

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // No unknown sample leaves the input stage once out of reset
  a_smp_known: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !$isunknown(smp_o)
  ) else $error("adc_input_fmt: unknown sample");

endmodule

/* source/acq_counter.sv */
////////////////////////////////////////
// Acquisition counter
// Decimation timer making the sample
// strobe, and phase sample counter
////////////////////////////////////////

`timescale 1ns/1ns

module acq_counter (
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // Decimation, strobe every dec_i+1 cycles
  input  logic [scope_pkg::DEC_W-1:0]   dec_i,
  // Phase counter control from the FSM
  input  logic                          cnt_clr_i,
  input  logic                          cnt_en_i,
  input  scope_pkg::addr_t              cnt_len_i,
  output logic                          smp_stb_o,
  output logic                          cnt_done_o
);

  import scope_pkg::*;

  logic [DEC_W-1:0] dec_cnt;
  addr_t            cnt;
  addr_t            cnt_nxt;

  // Free running timer, wraps at dec_i
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dec_cnt <= '0;
    end else if (dec_cnt >= dec_i) begin
      dec_cnt <= '0;
    end else begin
      dec_cnt <= dec_cnt + 1'b1;
    end
  end

  // Strobe on the last timer cycle, always high for dec_i == 0
  assign smp_stb_o = (dec_cnt == dec_i);

  // Phase counter, clear wins over count
  assign cnt_nxt = cnt + 1'b1;

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      cnt <= '0;
    end else if (cnt_clr_i) begin
      cnt <= '0;
    end else if (cnt_en_i && smp_stb_o) begin
      cnt <= cnt_nxt;
    end
  end

  // Done on the strobe that reaches the length
  // A zero length wraps and so spans the full buffer
  assign cnt_done_o = cnt_en_i && smp_stb_o && (cnt_nxt == cnt_len_i);

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // FSM must stop counting once the phase length is reached
  a_cnt_bound: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    (cnt_en_i && (cnt_len_i != '0)) |-> (cnt <= cnt_len_i)
  ) else $error("acq_counter: count past phase length");

endmodule

/* source/scope_trigger.sv */
////////////////////////////////////////
// Scope trigger
// Selects software, external or level
// crossing trigger on decimated samples
////////////////////////////////////////

`timescale 1ns/1ns

module scope_trigger (
  input  logic                 adc_clk,
  input  logic                 top_rst,
  // Decimated sample stream
  input  scope_pkg::sample_t   smp_i,
  input  logic                 smp_stb_i,
  // Control
  input  logic                 arm_i,
  input  scope_pkg::trg_src_t  trg_src_i,
  input  scope_pkg::sample_t   trg_level_i,
  input  logic                 sw_trg_i,
  input  logic                 ext_trg_i,
  // Trigger pulse
  output logic                 trg_o
);

  import scope_pkg::*;

  sample_t smp_prev;
  logic    edge_pos;
  logic    edge_neg;
  logic    trg_hit;

  // Previous decimated sample, updated on every strobe
  // so the first armed strobe already has a valid history
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      smp_prev <= '0;
    end else if (smp_stb_i) begin
      smp_prev <= smp_i;
    end
  end

  // Level crossings, signed compare
  assign edge_pos = (smp_prev <  trg_level_i) && (smp_i >= trg_level_i);
  assign edge_neg = (smp_prev >= trg_level_i) && (smp_i <  trg_level_i);

  // Source select
  always_comb begin
    case (trg_src_i)
      TRG_SW:  trg_hit = sw_trg_i;
      TRG_EXT: trg_hit = smp_stb_i && ext_trg_i;
      TRG_POS: trg_hit = smp_stb_i && edge_pos;
      TRG_NEG: trg_hit = smp_stb_i && edge_neg;
      default: trg_hit = 1'b0;
    endcase
  end

  // Registered pulse
  // Held back for a cycle after firing so a held source gives one pulse
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      trg_o <= 1'b0;
    end else begin
      trg_o <= arm_i && trg_hit && !trg_o;
    end
  end

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // A trigger only comes out of an armed cycle
  a_trg_armed: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    $rose(trg_o) |-> $past(arm_i)
  ) else $error("scope_trigger: trigger while not armed");

endmodule

/* source/acq_fsm.sv */
////////////////////////////////////////
// Acquisition FSM
// Sequences pre-trigger, armed,
// post-trigger and done phases
////////////////////////////////////////

`timescale 1ns/1ns

module acq_fsm (
  input  logic                 adc_clk,
  input  logic                 top_rst,
  // Control
  input  logic                 start_i,
  input  scope_pkg::addr_t     pre_len_i,
  input  scope_pkg::addr_t     post_len_i,
  // From counter and trigger
  input  logic                 cnt_done_i,
  input  logic                 trg_i,
  // To counter
  output logic                 cnt_clr_o,
  output logic                 cnt_en_o,
  output scope_pkg::addr_t     cnt_len_o,
  // To trigger and buffer
  output logic                 arm_o,
  output logic                 wr_en_o,
  output logic                 trg_lat_o,
  // Status
  output logic                 busy_o,
  output logic                 triggered_o,
  output logic                 done_o
);

  import scope_pkg::*;

  acq_state_t state;
  acq_state_t state_nxt;

  ////////////////////////////////////////
  // State register
  ////////////////////////////////////////

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      state <= ACQ_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  // Start restarts from any state
  always_comb begin
    state_nxt = state;
    if (start_i) begin
      state_nxt = ACQ_PRE;
    end else begin
      case (state)
        ACQ_PRE:   if (cnt_done_i) state_nxt = ACQ_ARMED;
        ACQ_ARMED: if (trg_i)      state_nxt = ACQ_POST;
        ACQ_POST:  if (cnt_done_i) state_nxt = ACQ_DONE;
        default:   state_nxt = state;
      endcase
    end
  end

  ////////////////////////////////////////
  // Outputs
  ////////////////////////////////////////

  // Counter cleared on start and at the end of pre-trigger
  assign cnt_clr_o = start_i || ((state == ACQ_PRE) && cnt_done_i);
  assign cnt_en_o  = (state == ACQ_PRE) || (state == ACQ_POST);
  assign cnt_len_o = (state == ACQ_POST) ? post_len_i : pre_len_i;

  assign arm_o     = (state == ACQ_ARMED);
  assign trg_lat_o = (state == ACQ_ARMED) && trg_i && !start_i;

  // Buffer keeps writing until post-trigger is full
  assign wr_en_o     = (state == ACQ_PRE) || (state == ACQ_ARMED) || (state == ACQ_POST);
  assign busy_o      = wr_en_o;
  assign triggered_o = (state == ACQ_POST) || (state == ACQ_DONE);
  assign done_o      = (state == ACQ_DONE);

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  // Counter only reports done in a counting phase
  a_cnt_done_en: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    cnt_done_i |-> cnt_en_o
  ) else $error("acq_fsm: counter done outside a counting phase");

endmodule

/* source/capture_buffer.sv */
////////////////////////////////////////
// Capture buffer
// Circular sample memory with trigger
// address latch and registered read
////////////////////////////////////////

`timescale 1ns/1ns

module capture_buffer (
  input  logic                 adc_clk,
  input  logic                 top_rst,
  // Sample stream
  input  scope_pkg::sample_t   smp_i,
  input  logic                 smp_stb_i,
  // From the FSM
  input  logic                 wr_en_i,
  input  logic                 trg_lat_i,
  // Readout port
  input  scope_pkg::addr_t     rd_addr_i,
  output scope_pkg::sample_t   rd_dat_o,
  output scope_pkg::addr_t     trg_addr_o
);

  import scope_pkg::*;

  // Sample memory
  sample_t mem [BUF_DEPTH];

  addr_t   wr_ptr;

  ////////////////////////////////////////
  // Write side
  ////////////////////////////////////////

  always_ff @(posedge adc_clk) begin
    if (smp_stb_i && wr_en_i) begin
      mem[wr_ptr] <= smp_i;
    end
  end

  // Pointer wraps naturally at BUF_DEPTH
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      wr_ptr <= '0;
    end else if (smp_stb_i && wr_en_i) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  // Trigger address latch
  // trg_lat comes a cycle after the deciding strobe, whose write
  // has already moved the pointer on by one
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      trg_addr_o <= '0;
    end else if (trg_lat_i) begin
      trg_addr_o <= wr_ptr - 1'b1;
    end
  end

  ////////////////////////////////////////
  // Read side
  ////////////////////////////////////////

  // One cycle read latency
  always_ff @(posedge adc_clk) begin
    rd_dat_o <= mem[rd_addr_i];
  end

endmodule

/* source/scope_top.sv */
////////////////////////////////////////
// Scope channel top
// One ADC acquisition channel with
// trigger and capture buffer
////////////////////////////////////////

`timescale 1ns/1ns

module scope_top (
  input  logic                          adc_clk,
  input  logic                          top_rst,
  // ADC
  input  logic [scope_pkg::ADC_W-1:0]   adc_dat_i,
  // Configuration
  input  logic [scope_pkg::DEC_W-1:0]   dec_i,
  input  logic                          start_i,
  input  logic                          sw_trg_i,
  input  logic                          ext_trg_i,
  input  scope_pkg::trg_src_t           trg_src_i,
  input  scope_pkg::sample_t            trg_level_i,
  input  scope_pkg::addr_t              pre_len_i,
  input  scope_pkg::addr_t              post_len_i,
  // Readout
  input  scope_pkg::addr_t              rd_addr_i,
  output scope_pkg::sample_t            rd_dat_o,
  output scope_pkg::addr_t              trg_addr_o,
  // Status
  output logic                          busy_o,
  output logic                          triggered_o,
  output logic                          done_o
);

  import scope_pkg::*;

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  sample_t smp;
  logic    smp_stb;
  logic    cnt_clr;
  logic    cnt_en;
  addr_t   cnt_len;
  logic    cnt_done;
  logic    arm;
  logic    trg;
  logic    wr_en;
  logic    trg_lat;

  // Input register and sign conversion
  adc_input_fmt fmt0 (
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_dat_i (adc_dat_i),
    .smp_o     (smp)
  );

  // Decimation strobe and phase counter
  acq_counter cnt0 (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .dec_i      (dec_i),
    .cnt_clr_i  (cnt_clr),
    .cnt_en_i   (cnt_en),
    .cnt_len_i  (cnt_len),
    .smp_stb_o  (smp_stb),
    .cnt_done_o (cnt_done)
  );

  scope_trigger trg0 (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .smp_i       (smp),
    .smp_stb_i   (smp_stb),
    .arm_i       (arm),
    .trg_src_i   (trg_src_i),
    .trg_level_i (trg_level_i),
    .sw_trg_i    (sw_trg_i),
    .ext_trg_i   (ext_trg_i),
    .trg_o       (trg)
  );

  acq_fsm fsm0 (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .start_i     (start_i),
    .pre_len_i   (pre_len_i),
    .post_len_i  (post_len_i),
    .cnt_done_i  (cnt_done),
    .trg_i       (trg),
    .cnt_clr_o   (cnt_clr),
    .cnt_en_o    (cnt_en),
    .cnt_len_o   (cnt_len),
    .arm_o       (arm),
    .wr_en_o     (wr_en),
    .trg_lat_o   (trg_lat),
    .busy_o      (busy_o),
    .triggered_o (triggered_o),
    .done_o      (done_o)
  );

  capture_buffer buf0 (
    .adc_clk    (adc_clk),
    .top_rst    (top_rst),
    .smp_i      (smp),
    .smp_stb_i  (smp_stb),
    .wr_en_i    (wr_en),
    .trg_lat_i  (trg_lat),
    .rd_addr_i  (rd_addr_i),
    .rd_dat_o   (rd_dat_o),
    .trg_addr_o (trg_addr_o)
  );

endmodule

/* testbench/tb_scope_top.sv */
////////////////////////////////////////
// Scope channel testbench
// Directed captures with software, edge,
// external and decimated triggers
////////////////////////////////////////

`timescale 1ns/1ns

module tb_scope_top;

  import scope_pkg::*;

  ////////////////////////////////////////
  // Test constants
  ////////////////////////////////////////

  localparam int PRE_LEN  = 16;
  localparam int POST_LEN = 24;
  localparam int SLACK    = 250;
  // Per capture bound, (pre + post + 8) * (dec + 1) plus slack
  localparam int BOUND_D0 = (PRE_LEN + POST_LEN + 8) * 1 + SLACK;
  localparam int BOUND_D3 = (PRE_LEN + POST_LEN + 8) * 4 + SLACK;
  // Idle test, six captures at dec 0, one at dec 3
  localparam int CYCLE_LIMIT = 50 + 6 * BOUND_D0 + BOUND_D3;
  localparam int WAIT_MAX = 400;
  localparam int REC_MAX  = 4096;

  // Stimulus sources
  localparam int SRC_NOISE = 0;
  localparam int SRC_FLAT  = 1;
  localparam int SRC_RAMP  = 2;

  // Status flag select
  localparam int ST_BUSY = 0;
  localparam int ST_TRIG = 1;
  localparam int ST_DONE = 2;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic             adc_clk;
  logic             top_rst;
  logic [ADC_W-1:0] adc_dat_i;
  logic [DEC_W-1:0] dec_i;
  logic             start_i;
  logic             sw_trg_i;
  logic             ext_trg_i;
  trg_src_t         trg_src_i;
  sample_t          trg_level_i;
  addr_t            pre_len_i;
  addr_t            post_len_i;
  addr_t            rd_addr_i;
  sample_t          rd_dat_o;
  addr_t            trg_addr_o;
  logic             busy_o;
  logic             triggered_o;
  logic             done_o;

  // Stimulus state and record of every driven word
  logic [31:0]      lcg_state;
  int               src_mode;
  sample_t          flat_smp;
  sample_t          ramp_smp;
  sample_t          ramp_step;
  logic [ADC_W-1:0] rec [REC_MAX];
  int               nrec;
  int               errors;
  int               checks;
  int               cycle_cnt = 0;

  scope_top dut0 (
    .adc_clk     (adc_clk),
    .top_rst     (top_rst),
    .adc_dat_i   (adc_dat_i),
    .dec_i       (dec_i),
    .start_i     (start_i),
    .sw_trg_i    (sw_trg_i),
    .ext_trg_i   (ext_trg_i),
    .trg_src_i   (trg_src_i),
    .trg_level_i (trg_level_i),
    .pre_len_i   (pre_len_i),
    .post_len_i  (post_len_i),
    .rd_addr_i   (rd_addr_i),
    .rd_dat_o    (rd_dat_o),
    .trg_addr_o  (trg_addr_o),
    .busy_o      (busy_o),
    .triggered_o (triggered_o),
    .done_o      (done_o)
  );

  // 10 ns clock
  initial adc_clk = 1'b0;
  always #5 adc_clk = ~adc_clk;

  // Watchdog
  always @(posedge adc_clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("Timeout: run went past %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Models and helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Expected sample, raw sign bit then inverted lower bits
  function automatic sample_t to_sample(input logic [ADC_W-1:0] raw);
    return {raw[ADC_W-1], ~raw[ADC_W-2:0]};
  endfunction

  // Raw word that converts to the wanted sample
  function automatic logic [ADC_W-1:0] raw_for(input sample_t s);
    return {s[ADC_W-1], ~s[ADC_W-2:0]};
  endfunction

  // Converted sample of a recorded word
  function automatic sample_t rec_sample(input int i);
    return to_sample(rec[i[11:0]]);
  endfunction

  function automatic logic status_bit(input int sel);
    logic b;
    case (sel)
      ST_BUSY: b = busy_o;
      ST_TRIG: b = triggered_o;
      default: b = done_o;
    endcase
    return b;
  endfunction

  // One clock of stimulus, 1 ns after the edge
  // Pulses set by a test last until the next call
  task automatic drive_cycle();
    logic [ADC_W-1:0] raw;
    @(posedge adc_clk);
    #1;
    start_i   = 1'b0;
    sw_trg_i  = 1'b0;
    ext_trg_i = 1'b0;
    case (src_mode)
      SRC_FLAT: raw = raw_for(flat_smp);
      SRC_RAMP: begin
        raw      = raw_for(ramp_smp);
        ramp_smp = ramp_smp + ramp_step;
      end
      default: begin
        lcg_state = lcg_next(lcg_state);
        raw       = lcg_state[31:16];
      end
    endcase
    adc_dat_i = raw;
    if (nrec < REC_MAX) begin
      rec[nrec[11:0]] = raw;
    end
    nrec++;
  endtask

  task automatic wait_status(input int sel, input string name);
    int n;
    n = 0;
    while (status_bit(sel) !== 1'b1 && n < WAIT_MAX) begin
      drive_cycle();
      n++;
    end
    if (status_bit(sel) !== 1'b1) begin
      errors++;
      $display("ERROR t=%0t: %s did not rise within %0d cycles", $time, name, WAIT_MAX);
    end
  endtask

  // Pulse start and wait for the busy flag
  task automatic start_acq(output int start_idx);
    drive_cycle();
    start_i   = 1'b1;
    start_idx = nrec - 1;
    wait_status(ST_BUSY, "busy_o");
  endtask

  // Buffer read, one cycle latency
  task automatic read_word(input addr_t addr, output sample_t dat);
    @(posedge adc_clk);
    #1;
    rd_addr_i = addr;
    @(posedge adc_clk);
    #1;
    dat = rd_dat_o;
  endtask

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_sample(input string name, input sample_t got, input sample_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL t=%0t %s: got %b expected %b", $time, name, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Tests
  ////////////////////////////////////////

  // Idle after reset, software pulses ignored
  task automatic test_reset_idle();
    int i;
    check_addr("trg_addr_o", trg_addr_o, '0);
    for (i = 0; i < 12; i++) begin
      drive_cycle();
      sw_trg_i = i[0];
      check_bit("busy_o", busy_o, 1'b0);
      check_bit("triggered_o", triggered_o, 1'b0);
      check_bit("done_o", done_o, 1'b0);
    end
  endtask

  // Rest of a software capture after start
  // Trigger word found in the record, post words follow it
  task automatic finish_sw(input int start_idx, input bit from_reset);
    int      i;
    int      k;
    int      hit;
    sample_t w;
    repeat (PRE_LEN + 4) drive_cycle();
    sw_trg_i = 1'b1;
    wait_status(ST_DONE, "done_o");
    check_bit("triggered_o", triggered_o, 1'b1);
    read_word(trg_addr_o, w);
    hit = -1;
    for (i = start_idx; i < nrec && i < REC_MAX; i++) begin
      if (hit < 0 && rec_sample(i) == w) begin
        hit = i;
      end
    end
    if (hit < 0) begin
      errors++;
      $display("ERROR t=%0t: trigger word %0d is not among the driven samples", $time, w);
    end else begin
      // First capture after reset starts writing at address 0
      if (from_reset) begin
        check_addr("trg_addr_o", trg_addr_o, addr_t'(hit - start_idx));
      end
      for (k = 1; k <= POST_LEN; k++) begin
        read_word(trg_addr_o + addr_t'(k), w);
        check_sample("rd_dat_o post", w, rec_sample(hit + k));
      end
    end
  endtask

  task automatic capture_sw(input bit from_reset);
    int start_idx;
    trg_src_i = TRG_SW;
    src_mode  = SRC_NOISE;
    dec_i     = 8'd0;
    start_acq(start_idx);
    finish_sw(start_idx, from_reset);
  endtask

  // Flat run, then a ramp whose first value crosses the level
  task automatic capture_edge(input trg_src_t src, input sample_t level, input sample_t flat,
                              input sample_t first, input sample_t step);
    int      start_idx;
    int      k;
    sample_t w;
    trg_src_i   = src;
    trg_level_i = level;
    dec_i       = 8'd0;
    flat_smp    = flat;
    src_mode    = SRC_FLAT;
    // Flat value already in the pipeline at start
    repeat (4) drive_cycle();
    start_acq(start_idx);
    repeat (PRE_LEN + 4) drive_cycle();
    ramp_smp  = first;
    ramp_step = step;
    src_mode  = SRC_RAMP;
    wait_status(ST_DONE, "done_o");
    check_bit("triggered_o", triggered_o, 1'b1);
    read_word(trg_addr_o, w);
    check_sample("rd_dat_o trigger", w, first);
    for (k = 1; k <= POST_LEN; k++) begin
      read_word(trg_addr_o + addr_t'(k), w);
      check_sample("rd_dat_o post", w, sample_t'(int'(first) + int'(step) * k));
    end
    for (k = 1; k <= PRE_LEN; k++) begin
      read_word(trg_addr_o - addr_t'(k), w);
      check_sample("rd_dat_o pre", w, flat);
    end
  endtask

  // External trigger, nothing completes before ext_trg_i
  task automatic capture_ext();
    int      start_idx;
    int      k;
    int      ext_idx;
    sample_t w;
    trg_src_i = TRG_EXT;
    src_mode  = SRC_NOISE;
    dec_i     = 8'd0;
    start_acq(start_idx);
    for (k = 0; k < PRE_LEN + 24; k++) begin
      drive_cycle();
      check_bit("done_o", done_o, 1'b0);
      check_bit("triggered_o", triggered_o, 1'b0);
    end
    ext_trg_i = 1'b1;
    ext_idx   = nrec - 1;
    wait_status(ST_DONE, "done_o");
    check_bit("triggered_o", triggered_o, 1'b1);
    // Sample current with the pulse was driven a cycle before it
    read_word(trg_addr_o, w);
    check_sample("rd_dat_o trigger", w, rec_sample(ext_idx - 1));
  endtask

  // Unit ramp every clock, one sample kept in four
  task automatic capture_decimated();
    int      start_idx;
    int      k;
    sample_t w;
    sample_t w_prev;
    dec_i       = 8'd3;
    trg_src_i   = TRG_POS;
    trg_level_i = 16'sd500;
    ramp_smp    = sample_t'(500 - (4 * PRE_LEN + 60));
    ramp_step   = 16'sd1;
    src_mode    = SRC_RAMP;
    start_acq(start_idx);
    wait_status(ST_DONE, "done_o");
    check_bit("triggered_o", triggered_o, 1'b1);
    read_word(trg_addr_o - addr_t'(1), w);
    check_bit("word before trigger below level", w < trg_level_i, 1'b1);
    read_word(trg_addr_o, w_prev);
    check_bit("trigger word at level", w_prev >= trg_level_i, 1'b1);
    for (k = 1; k <= POST_LEN; k++) begin
      read_word(trg_addr_o + addr_t'(k), w);
      check_sample("rd_dat_o step", w, sample_t'(w_prev + 16'sd4));
      w_prev = w;
    end
    dec_i = 8'd0;
  endtask

  // Start during post-trigger, then a full capture
  task automatic capture_restart();
    int start_idx;
    trg_src_i = TRG_SW;
    src_mode  = SRC_NOISE;
    dec_i     = 8'd0;
    start_acq(start_idx);
    repeat (PRE_LEN + 4) drive_cycle();
    sw_trg_i = 1'b1;
    wait_status(ST_TRIG, "triggered_o");
    drive_cycle();
    check_bit("done_o", done_o, 1'b0);
    start_i   = 1'b1;
    start_idx = nrec - 1;
    drive_cycle();
    check_bit("busy_o", busy_o, 1'b1);
    check_bit("triggered_o", triggered_o, 1'b0);
    check_bit("done_o", done_o, 1'b0);
    finish_sw(start_idx, 1'b0);
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    adc_dat_i   = '0;
    dec_i       = 8'd0;
    start_i     = 1'b0;
    sw_trg_i    = 1'b0;
    ext_trg_i   = 1'b0;
    trg_src_i   = TRG_SW;
    trg_level_i = '0;
    pre_len_i   = addr_t'(PRE_LEN);
    post_len_i  = addr_t'(POST_LEN);
    rd_addr_i   = '0;
    lcg_state   = 32'h6e11bb04;
    src_mode    = SRC_NOISE;
    flat_smp    = '0;
    ramp_smp    = '0;
    ramp_step   = 16'sd1;
    nrec        = 0;
    errors      = 0;
    checks      = 0;
    top_rst     = 1'b1;
    repeat (2) @(posedge adc_clk);
    #1;
    top_rst = 1'b0;

    test_reset_idle();
    capture_sw(1'b1);
    capture_edge(TRG_POS, 16'sd100, -16'sd200, 16'sd100, 16'sd3);
    capture_edge(TRG_NEG, -16'sd100, 16'sd300, -16'sd101, -16'sd3);
    capture_ext();
    capture_decimated();
    capture_restart();

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* build.f */
source/scope_pkg.sv
source/adc_input_fmt.sv
source/acq_counter.sv
source/scope_trigger.sv
source/acq_fsm.sv
source/capture_buffer.sv
source/scope_top.sv
testbench/tb_scope_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the scope channel testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_scope_top \
  -Mdir obj_dir -o sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulator exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Simulation passed"; then
  exit 0
fi
exit 1
